//--- include/bgpu_defines.svh
// ====================
// Front end sizing. BGPU_NUM_WARPS must equal 2**BGPU_WID_WIDTH,
// since the warp pointer wraps by plain truncation
// ====================

`ifndef BGPU_DEFINES_SVH
`define BGPU_DEFINES_SVH

// Program counter width, counted in instruction words
`define BGPU_PC_WIDTH 16

// Number of warps and the width of a warp id
`define BGPU_NUM_WARPS 4
`define BGPU_WID_WIDTH 2

// Encoded instruction word
`define BGPU_INST_WIDTH 32

// Register index carried in destination and operand fields
`define BGPU_REG_IDX_WIDTH 8

`endif

//--- logic/bgpu_pkg.sv
// ====================
// Types shared by the warp front end. The opcode is the top byte
// of a 32-bit instruction word, and the all-ones opcode means stop
// ====================

`include "bgpu_defines.svh"

package bgpu_pkg;

    typedef logic [`BGPU_PC_WIDTH-1:0]      pc_t;
    typedef logic [`BGPU_WID_WIDTH-1:0]     wid_t;
    typedef logic [`BGPU_REG_IDX_WIDTH-1:0] reg_idx_t;
    typedef logic [`BGPU_INST_WIDTH-1:0]    enc_inst_t;

    // Execution unit, value 3 is reserved (used by stop)
    typedef enum logic [1:0] {
        EU_IU  = 2'd0,
        EU_LSU = 2'd1,
        EU_BRU = 2'd2
    } eu_e;

    typedef enum logic [5:0] {
        IU_ADD  = 6'd0,
        IU_SUB  = 6'd1,
        IU_AND  = 6'd2,
        IU_OR   = 6'd3,
        IU_XOR  = 6'd4,
        IU_SLL  = 6'd5,
        IU_ADDI = 6'd6,
        IU_SUBI = 6'd7,
        IU_SLLI = 6'd8
    } iu_subtype_e;

    typedef enum logic [5:0] {
        BRU_BR   = 6'd0,
        BRU_JMP  = 6'd1,
        BRU_SYNC = 6'd2
    } bru_subtype_e;

    // Opcode byte, subtype meaning depends on eu
    typedef struct packed {
        eu_e        eu;
        logic [5:0] subtype;
    } inst_t;

    typedef struct packed {
        wid_t warp_id;
        pc_t  pc;
    } fetch_req_t;

    typedef struct packed {
        wid_t      warp_id;
        pc_t       pc;
        enc_inst_t word;
    } fetched_t;

    typedef struct packed {
        wid_t                warp_id;
        pc_t                 pc;
        inst_t               inst;
        reg_idx_t            dst;
        reg_idx_t [1:0]      operands;
        logic     [1:0]      operands_required;
        logic                branch;
    } dec_inst_t;

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        BUS  = 2'd1,
        HOLD = 2'd2
    } fetcher_state_e;

endpackage : bgpu_pkg

//--- logic/warp_fetcher.sv
// ====================
// Round-robin warp picker, one instruction in flight per warp.
// Launches to an already active warp are dropped
// ====================

`include "bgpu_defines.svh"

module warp_fetcher (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic                       start_i,
    input  bgpu_pkg::wid_t             start_warp_i,
    input  bgpu_pkg::pc_t              start_pc_i,
    output logic                       req_valid_o,
    output bgpu_pkg::fetch_req_t       req_o,
    input  logic                       req_ready_i,
    input  logic                       resolved_i,
    input  bgpu_pkg::wid_t             res_warp_i,
    input  bgpu_pkg::pc_t              res_next_pc_i,
    input  logic                       res_stop_i,
    output logic [`BGPU_NUM_WARPS-1:0] warps_active_o
);

    bgpu_pkg::pc_t              pc_q [`BGPU_NUM_WARPS];
    logic [`BGPU_NUM_WARPS-1:0] active_q;
    logic [`BGPU_NUM_WARPS-1:0] pending_q;
    bgpu_pkg::wid_t             ptr_q;
    logic                       req_valid_q;
    bgpu_pkg::fetch_req_t       req_q;

    logic                       found;
    bgpu_pkg::wid_t             sel;

    logic                       launch;
    logic                       accept;

    assign launch = start_i && !active_q[start_warp_i];
    assign accept = req_valid_q && req_ready_i;

    // First ready warp, starting at the rotating pointer
    always_comb begin
        bgpu_pkg::wid_t idx;
        found = 1'b0;
        sel   = '0;
        for (int i = 0; i < `BGPU_NUM_WARPS; i++) begin
            idx = bgpu_pkg::wid_t'(ptr_q + i);
            if (!found && active_q[idx] && !pending_q[idx]) begin
                found = 1'b1;
                sel   = idx;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            active_q    <= '0;
            pending_q   <= '0;
            ptr_q       <= '0;
            req_valid_q <= 1'b0;
        end else begin
            if (accept) begin
                req_valid_q                <= 1'b0;
                pending_q[req_q.warp_id]   <= 1'b1;
            end else if (!req_valid_q && found) begin
                req_valid_q <= 1'b1;
                ptr_q       <= sel + 1'b1;
            end
            // Resolved warp is pending, so it never collides with accept
            if (resolved_i) begin
                pending_q[res_warp_i] <= 1'b0;
                if (res_stop_i) begin
                    active_q[res_warp_i] <= 1'b0;
                end
            end
            if (launch) begin
                active_q[start_warp_i] <= 1'b1;
            end
        end
    end

    // PC table and offered request
    always_ff @(posedge clk_i) begin
        if (!req_valid_q && found) begin
            req_q.warp_id <= sel;
            req_q.pc      <= pc_q[sel];
        end
        if (resolved_i && !res_stop_i) begin
            pc_q[res_warp_i] <= res_next_pc_i;
        end
        if (launch) begin
            pc_q[start_warp_i] <= start_pc_i;
        end
    end

    assign req_valid_o    = req_valid_q;
    assign req_o          = req_q;
    assign warps_active_o = active_q;

endmodule : warp_fetcher

//--- logic/inst_fetch_wb.sv
// ====================
// Wishbone classic read master, one read outstanding.
// The word is held until the decoder consumes it
// ====================

module inst_fetch_wb (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 req_valid_i,
    input  bgpu_pkg::fetch_req_t req_i,
    output logic                 req_ready_o,
    output logic                 wb_cyc_o,
    output logic                 wb_stb_o,
    output logic                 wb_we_o,
    output bgpu_pkg::pc_t        wb_adr_o,
    input  bgpu_pkg::enc_inst_t  wb_dat_i,
    input  logic                 wb_ack_i,
    output logic                 fetched_valid_o,
    output bgpu_pkg::fetched_t   fetched_o,
    input  logic                 consumed_i
);

    bgpu_pkg::fetcher_state_e state_q;
    bgpu_pkg::fetch_req_t     req_q;
    bgpu_pkg::enc_inst_t      word_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= bgpu_pkg::IDLE;
        end else begin
            case (state_q)
                bgpu_pkg::IDLE: begin
                    if (req_valid_i) begin
                        state_q <= bgpu_pkg::BUS;
                    end
                end
                bgpu_pkg::BUS: begin
                    if (wb_ack_i) begin
                        state_q <= bgpu_pkg::HOLD;
                    end
                end
                bgpu_pkg::HOLD: begin
                    if (consumed_i) begin
                        state_q <= bgpu_pkg::IDLE;
                    end
                end
                default: begin
                    state_q <= bgpu_pkg::IDLE;
                end
            endcase
        end
    end

    // Request and read data capture
    always_ff @(posedge clk_i) begin
        if (state_q == bgpu_pkg::IDLE && req_valid_i) begin
            req_q <= req_i;
        end
        if (state_q == bgpu_pkg::BUS && wb_ack_i) begin
            word_q <= wb_dat_i;
        end
    end

    assign req_ready_o = state_q == bgpu_pkg::IDLE;

    // Cycle and strobe rise together and drop after ack
    assign wb_cyc_o = state_q == bgpu_pkg::BUS;
    assign wb_stb_o = state_q == bgpu_pkg::BUS;
    assign wb_we_o  = 1'b0;
    assign wb_adr_o = req_q.pc;

    assign fetched_valid_o   = state_q == bgpu_pkg::HOLD;
    assign fetched_o.warp_id = req_q.warp_id;
    assign fetched_o.pc      = req_q.pc;
    assign fetched_o.word    = word_q;

endmodule : inst_fetch_wb

//--- logic/decoder.sv
// ====================
// Combinational decode. Jump, sync and stop resolve at once and are
// never pushed. Branches go out flagged and are assumed not taken
// ====================

module decoder (
    input  logic                fetched_valid_i,
    input  bgpu_pkg::fetched_t  fetched_i,
    output logic                consumed_o,
    output logic                push_valid_o,
    output bgpu_pkg::dec_inst_t push_o,
    input  logic                push_ready_i,
    output logic                resolved_o,
    output bgpu_pkg::wid_t      res_warp_o,
    output bgpu_pkg::pc_t       res_next_pc_o,
    output logic                res_stop_o
);

    bgpu_pkg::inst_t inst;
    logic            is_stop;
    logic            is_control;
    logic [1:0]      op_req;
    logic            branch;
    bgpu_pkg::pc_t   next_pc;

    assign inst    = bgpu_pkg::inst_t'(fetched_i.word[31:24]);
    assign is_stop = fetched_i.word[31:24] == 8'hff;

    always_comb begin
        next_pc    = fetched_i.pc + 1'b1;
        op_req     = 2'b00;
        branch     = 1'b0;
        is_control = is_stop;

        case (inst.eu)
            bgpu_pkg::EU_IU: begin
                if (inst.subtype inside {bgpu_pkg::IU_ADD, bgpu_pkg::IU_SUB,
                                         bgpu_pkg::IU_AND, bgpu_pkg::IU_OR,
                                         bgpu_pkg::IU_XOR, bgpu_pkg::IU_SLL}) begin
                    op_req = 2'b11;
                end else if (inst.subtype inside {bgpu_pkg::IU_ADDI, bgpu_pkg::IU_SUBI,
                                                  bgpu_pkg::IU_SLLI}) begin
                    // Operand 0 carries an immediate
                    op_req = 2'b10;
                end
            end
            bgpu_pkg::EU_LSU: begin
                // Address and store data
                op_req = 2'b11;
            end
            bgpu_pkg::EU_BRU: begin
                if (inst.subtype == bgpu_pkg::BRU_JMP) begin
                    next_pc    = fetched_i.pc + 1'b1
                               + bgpu_pkg::pc_t'($signed(fetched_i.word[15:0]));
                    is_control = 1'b1;
                end else if (inst.subtype == bgpu_pkg::BRU_SYNC) begin
                    is_control = 1'b1;
                end else if (inst.subtype == bgpu_pkg::BRU_BR) begin
                    // Condition register in operand 1
                    op_req = 2'b10;
                    branch = 1'b1;
                end
            end
            default: begin
                op_req = 2'b00;
            end
        endcase
    end

    assign push_valid_o = fetched_valid_i && !is_control;

    // Control words leave at once, the rest on a buffer handshake
    assign consumed_o = fetched_valid_i && (is_control || push_ready_i);

    assign push_o.warp_id           = fetched_i.warp_id;
    assign push_o.pc                = fetched_i.pc;
    assign push_o.inst              = inst;
    assign push_o.dst               = fetched_i.word[23:16];
    assign push_o.operands[0]       = fetched_i.word[15:8];
    assign push_o.operands[1]       = fetched_i.word[7:0];
    assign push_o.operands_required = op_req;
    assign push_o.branch            = branch;

    assign resolved_o    = consumed_o;
    assign res_warp_o    = fetched_i.warp_id;
    assign res_next_pc_o = next_pc;
    assign res_stop_o    = is_stop;

endmodule : decoder

//--- logic/dispatch_buffer.sv
// ====================
// Two-entry FIFO, ready while not full.
// A pushed entry is visible at the output one edge later
// ====================

module dispatch_buffer (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                push_valid_i,
    input  bgpu_pkg::dec_inst_t push_i,
    output logic                push_ready_o,
    output logic                disp_valid_o,
    output bgpu_pkg::dec_inst_t disp_o,
    input  logic                disp_ready_i
);

    bgpu_pkg::dec_inst_t mem_q [2];
    logic                wr_ptr_q;
    logic                rd_ptr_q;
    logic [1:0]          count_q;

    logic                push;
    logic                pop;

    assign push_ready_o = count_q != 2'd2;
    assign disp_valid_o = count_q != 2'd0;
    assign disp_o       = mem_q[rd_ptr_q];

    assign push = push_valid_i && push_ready_o;
    assign pop  = disp_valid_o && disp_ready_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            count_q  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr_q <= !wr_ptr_q;
            end
            if (pop) begin
                rd_ptr_q <= !rd_ptr_q;
            end
            // Simultaneous push and pop keep the count
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= push_i;
        end
    end

endmodule : dispatch_buffer

//--- logic/bgpu_frontend.sv
// ====================
// Warp front end top. Wishbone on the memory side,
// valid/ready on the dispatch side
// ====================

`include "bgpu_defines.svh"

module bgpu_frontend (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic                       start_i,
    input  bgpu_pkg::wid_t             start_warp_i,
    input  bgpu_pkg::pc_t              start_pc_i,
    output logic [`BGPU_NUM_WARPS-1:0] warps_active_o,
    output logic                       wb_cyc_o,
    output logic                       wb_stb_o,
    output logic                       wb_we_o,
    output bgpu_pkg::pc_t              wb_adr_o,
    input  bgpu_pkg::enc_inst_t        wb_dat_i,
    input  logic                       wb_ack_i,
    output logic                       disp_valid_o,
    output bgpu_pkg::dec_inst_t        disp_o,
    input  logic                       disp_ready_i
);

    logic                 req_valid;
    logic                 req_ready;
    bgpu_pkg::fetch_req_t req;

    logic                 fetched_valid;
    bgpu_pkg::fetched_t   fetched;
    logic                 consumed;

    logic                 push_valid;
    logic                 push_ready;
    bgpu_pkg::dec_inst_t  push;

    logic                 resolved;
    bgpu_pkg::wid_t       res_warp;
    bgpu_pkg::pc_t        res_next_pc;
    logic                 res_stop;

    warp_fetcher u_warp_fetcher (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .start_i        (start_i),
        .start_warp_i   (start_warp_i),
        .start_pc_i     (start_pc_i),
        .req_valid_o    (req_valid),
        .req_o          (req),
        .req_ready_i    (req_ready),
        .resolved_i     (resolved),
        .res_warp_i     (res_warp),
        .res_next_pc_i  (res_next_pc),
        .res_stop_i     (res_stop),
        .warps_active_o (warps_active_o)
    );

    inst_fetch_wb u_inst_fetch_wb (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .req_valid_i     (req_valid),
        .req_i           (req),
        .req_ready_o     (req_ready),
        .wb_cyc_o        (wb_cyc_o),
        .wb_stb_o        (wb_stb_o),
        .wb_we_o         (wb_we_o),
        .wb_adr_o        (wb_adr_o),
        .wb_dat_i        (wb_dat_i),
        .wb_ack_i        (wb_ack_i),
        .fetched_valid_o (fetched_valid),
        .fetched_o       (fetched),
        .consumed_i      (consumed)
    );

    decoder u_decoder (
        .fetched_valid_i (fetched_valid),
        .fetched_i       (fetched),
        .consumed_o      (consumed),
        .push_valid_o    (push_valid),
        .push_o          (push),
        .push_ready_i    (push_ready),
        .resolved_o      (resolved),
        .res_warp_o      (res_warp),
        .res_next_pc_o   (res_next_pc),
        .res_stop_o      (res_stop)
    );

    dispatch_buffer u_dispatch_buffer (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .push_valid_i (push_valid),
        .push_i       (push),
        .push_ready_o (push_ready),
        .disp_valid_o (disp_valid_o),
        .disp_o       (disp_o),
        .disp_ready_i (disp_ready_i)
    );

endmodule : bgpu_frontend

//--- test/bgpu_frontend_asserts.sv
// ====================
// Bus and handshake rules of the front end top, bound by bind.
// Wishbone checks assume a single outstanding read
// ====================

`include "bgpu_defines.svh"

module bgpu_frontend_asserts (
    input logic                       clk_i,
    input logic                       reset_i,
    input logic                       wb_cyc_i,
    input logic                       wb_stb_i,
    input bgpu_pkg::pc_t              wb_adr_i,
    input logic                       wb_ack_i,
    input logic                       disp_valid_i,
    input bgpu_pkg::dec_inst_t        disp_i,
    input logic                       disp_ready_i,
    input logic [`BGPU_NUM_WARPS-1:0] warps_active_i
);

    // Strobe only inside a bus cycle
    assert property (@(posedge clk_i) disable iff (reset_i)
        wb_stb_i |-> wb_cyc_i)
        else $error("Wishbone stb high without cyc");

    // Address and strobe held until the slave acks
    assert property (@(posedge clk_i) disable iff (reset_i)
        wb_stb_i && !wb_ack_i |=> wb_stb_i && $stable(wb_adr_i))
        else $error("Wishbone request changed before ack");

    // Dispatch output held under back-pressure
    assert property (@(posedge clk_i) disable iff (reset_i)
        disp_valid_i && !disp_ready_i |=> disp_valid_i && $stable(disp_i))
        else $error("Dispatch output changed while stalled");

    // A reset edge leaves every output idle
    assert property (@(posedge clk_i)
        reset_i |=> !wb_cyc_i && !wb_stb_i && !disp_valid_i && warps_active_i == '0)
        else $error("Output active during reset");

endmodule : bgpu_frontend_asserts

bind bgpu_frontend bgpu_frontend_asserts u_asserts (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .wb_cyc_i       (wb_cyc_o),
    .wb_stb_i       (wb_stb_o),
    .wb_adr_i       (wb_adr_o),
    .wb_ack_i       (wb_ack_i),
    .disp_valid_i   (disp_valid_o),
    .disp_i         (disp_o),
    .disp_ready_i   (disp_ready_i),
    .warps_active_i (warps_active_o)
);

//--- test/tb_bgpu_frontend.sv
// ====================
// Random programs in a 256-word memory, 32 words per warp,
// forward jumps only. Ack delay 0 to 3 cycles, random back-pressure
// ====================

`include "bgpu_defines.svh"

module tb_bgpu_frontend;

    localparam int timeout_cycles = 5000;
    localparam int region_words   = 32;

    logic                       clk;
    logic                       reset;
    logic                       start;
    bgpu_pkg::wid_t             start_warp;
    bgpu_pkg::pc_t              start_pc;
    logic [`BGPU_NUM_WARPS-1:0] warps_active;
    logic                       wb_cyc;
    logic                       wb_stb;
    logic                       wb_we;
    bgpu_pkg::pc_t              wb_adr;
    bgpu_pkg::enc_inst_t        wb_dat;
    logic                       wb_ack;
    logic                       disp_valid;
    bgpu_pkg::dec_inst_t        disp;
    logic                       disp_ready;

    logic [31:0]         lfsr_q;
    logic [31:0]         mem [256];
    bgpu_pkg::dec_inst_t exp_mem [`BGPU_NUM_WARPS][region_words];
    int                  exp_cnt [`BGPU_NUM_WARPS];
    int                  exp_head [`BGPU_NUM_WARPS];
    int                  total;
    int                  dispatched;
    int                  errors;
    int                  tests_run;
    int                  tests_failed;
    logic                aborted;
    logic                bus_busy;
    logic [1:0]          ack_wait;

    bgpu_frontend DUT (
        .clk_i          (clk),
        .reset_i        (reset),
        .start_i        (start),
        .start_warp_i   (start_warp),
        .start_pc_i     (start_pc),
        .warps_active_o (warps_active),
        .wb_cyc_o       (wb_cyc),
        .wb_stb_o       (wb_stb),
        .wb_we_o        (wb_we),
        .wb_adr_o       (wb_adr),
        .wb_dat_i       (wb_dat),
        .wb_ack_i       (wb_ack),
        .disp_valid_o   (disp_valid),
        .disp_o         (disp),
        .disp_ready_i   (disp_ready)
    );

    always #20 clk = !clk;

    // Steps the x^32 + x^22 + x^2 + x + 1 LFSR once per bit
    function automatic logic next_bit();
        logic fb;
        fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], next_bit()};
        end
        return v;
    endfunction

    // Bit i is set when operand i comes from a register
    function automatic logic [1:0] operands_needed(input logic [7:0] op);
        logic [1:0] needed;
        needed = 2'b00;
        if (op[7:6] == 2'd0 && op[5:0] <= 6'd5) begin
            needed = 2'b11;
        end else if (op[7:6] == 2'd0 && op[5:0] >= 6'd6 && op[5:0] <= 6'd8) begin
            needed = 2'b10;
        end else if (op[7:6] == 2'd1) begin
            needed = 2'b11;
        end else if (op == {2'd2, 6'd0}) begin
            needed = 2'b10;
        end
        return needed;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        errors++;
        $display("FAIL %s expected %0h actual %0h", name, exp, act);
    endtask

    task automatic report_problem(input string msg);
        errors++;
        $display("ERROR %s", msg);
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic fill_memory();
        logic [7:0]  op;
        logic [23:0] fields;
        logic [2:0]  kind;
        logic [15:0] off;
        int          base;
        // Unused words are stops tagged with their address
        for (int a = 0; a < 256; a++) begin
            mem[a] = {8'hff, 8'ha5, 8'(a), 8'(a) ^ 8'h3c};
        end
        for (int w = 0; w < `BGPU_NUM_WARPS; w++) begin
            base = w * region_words;
            for (int i = 0; i < region_words - 1; i++) begin
                kind   = 3'(rand_bits(3));
                fields = 24'(rand_bits(24));
                case (kind)
                    3'd0, 3'd1: op = {4'b0000, 4'(rand_bits(4))};
                    3'd2:       op = {2'd1, 6'(rand_bits(6))};
                    3'd3:       op = {2'd2, 6'd0};
                    3'd4:       op = {2'd2, 6'd2};
                    3'd5: begin
                        // Jump target stays at or before the closing stop
                        op  = {2'd2, 6'd1};
                        off = 16'(rand_bits(2));
                        if (int'(off) > region_words - 2 - i) begin
                            off = 16'(region_words - 2 - i);
                        end
                        fields[15:0] = off;
                    end
                    3'd6:       op = {3'b110, 5'(rand_bits(5))};
                    default:    op = {2'd0, 6'(6 + rand_bits(2))};
                endcase
                mem[base + i] = {op, fields};
            end
            mem[base + region_words - 1] = {8'hff, 24'(rand_bits(24))};
        end
    endtask

    // Walks each warp from its start PC and queues only non-control words
    task automatic build_model();
        bgpu_pkg::pc_t       pc;
        bgpu_pkg::dec_inst_t e;
        logic [31:0]         word;
        logic                done;
        int                  steps;
        total = 0;
        for (int w = 0; w < `BGPU_NUM_WARPS; w++) begin
            exp_cnt[w]  = 0;
            exp_head[w] = 0;
            pc          = 16'(w * region_words);
            done        = 1'b0;
            steps       = 0;
            while (!done && steps < 2 * region_words) begin
                word = mem[pc[7:0]];
                steps++;
                if (word[31:24] == 8'hff) begin
                    done = 1'b1;
                end else if (word[31:24] == {2'd2, 6'd1}) begin
                    pc = 16'(int'(pc) + 1 + int'($signed(word[15:0])));
                end else if (word[31:24] == {2'd2, 6'd2}) begin
                    pc = pc + 16'd1;
                end else begin
                    e                   = '0;
                    e.warp_id           = 2'(w);
                    e.pc                = pc;
                    e.inst              = bgpu_pkg::inst_t'(word[31:24]);
                    e.dst               = word[23:16];
                    e.operands[0]       = word[15:8];
                    e.operands[1]       = word[7:0];
                    e.operands_required = operands_needed(word[31:24]);
                    e.branch            = word[31:24] == {2'd2, 6'd0};
                    exp_mem[w][exp_cnt[w]] = e;
                    exp_cnt[w]++;
                    pc = pc + 16'd1;
                end
            end
            total += exp_cnt[w];
        end
    endtask

    task automatic take_entry(input bgpu_pkg::dec_inst_t d);
        bgpu_pkg::dec_inst_t e;
        logic [7:0]          op;
        int                  w;
        op = d.inst;
        w  = int'(d.warp_id);
        dispatched++;
        if (op == 8'hff || op == {2'd2, 6'd1} || op == {2'd2, 6'd2}) begin
            report_problem($sformatf("control opcode %0h reached the output", op));
        end
        if (exp_head[w] >= exp_cnt[w]) begin
            report_problem($sformatf("warp %0d dispatched after its stop, pc %0h",
                                     w, d.pc));
        end else begin
            e = exp_mem[w][exp_head[w]];
            exp_head[w]++;
            if (d.pc != e.pc) begin
                report_mismatch("stream pc", 32'(e.pc), 32'(d.pc));
            end
            if (d.inst != e.inst) begin
                report_mismatch("stream opcode", {24'h0, e.inst}, {24'h0, d.inst});
            end
            if (d.dst != e.dst) begin
                report_mismatch("stream dst", 32'(e.dst), 32'(d.dst));
            end
            if (d.operands[0] != e.operands[0]) begin
                report_mismatch("stream operand 0", 32'(e.operands[0]), 32'(d.operands[0]));
            end
            if (d.operands[1] != e.operands[1]) begin
                report_mismatch("stream operand 1", 32'(e.operands[1]), 32'(d.operands[1]));
            end
            if (d.operands_required != e.operands_required) begin
                report_mismatch("decode operands_required", 32'(e.operands_required),
                                32'(d.operands_required));
            end
            if (d.branch != e.branch) begin
                report_mismatch("decode branch", 32'(e.branch), 32'(d.branch));
            end
        end
    endtask

    // Memory slave and downstream consumer for one falling edge
    task automatic service_cycle();
        if (wb_cyc && wb_we) begin
            report_problem("Wishbone write seen on the fetch bus");
        end
        if (wb_ack) begin
            wb_ack = 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (wb_adr[15:8] != 8'h00) begin
                report_problem($sformatf("fetch outside memory at %0h", wb_adr));
            end
            if (!bus_busy) begin
                bus_busy = 1'b1;
                ack_wait = 2'(rand_bits(2));
            end
            if (ack_wait == 2'd0) begin
                wb_ack   = 1'b1;
                wb_dat   = mem[wb_adr[7:0]];
                bus_busy = 1'b0;
            end else begin
                ack_wait = ack_wait - 2'd1;
            end
        end
        disp_ready = next_bit();
        // The pop itself happens on the coming rising edge
        if (disp_valid && disp_ready) begin
            take_entry(disp);
        end
    endtask

    // Launch pulse at a running warp with another warp's start PC
    task automatic relaunch_running();
        bgpu_pkg::wid_t w;
        logic           fire;
        w     = 2'(rand_bits(2));
        fire  = next_bit();
        start = 1'b0;
        if (fire && warps_active[w]) begin
            start      = 1'b1;
            start_warp = w;
            start_pc   = 16'(((int'(w) + 2) % `BGPU_NUM_WARPS) * region_words);
        end
    endtask

    initial begin
        int errors_before;
        int cycles;
        clk          = 1'b0;
        reset        = 1'b1;
        start        = 1'b0;
        start_warp   = '0;
        start_pc     = '0;
        wb_dat       = '0;
        wb_ack       = 1'b0;
        disp_ready   = 1'b0;
        lfsr_q       = 32'h8d1c;
        dispatched   = 0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        aborted      = 1'b0;
        bus_busy     = 1'b0;
        ack_wait     = 2'd0;
        fill_memory();
        build_model();

        repeat (10) @(negedge clk);
        reset = 1'b0;

        errors_before = errors;
        for (int w = 0; w < `BGPU_NUM_WARPS; w++) begin
            @(negedge clk);
            service_cycle();
            start      = 1'b1;
            start_warp = 2'(w);
            start_pc   = 16'(w * region_words);
        end
        @(negedge clk);
        service_cycle();
        start = 1'b0;
        if (warps_active != '1) begin
            report_mismatch("launch active", 32'hf, 32'(warps_active));
        end
        report_test("launch", errors_before);

        // Warp 0 is still running, so this launch must be dropped
        errors_before = errors;
        if (!warps_active[0]) begin
            report_problem("warp 0 retired before its second launch");
        end
        start      = 1'b1;
        start_warp = 2'd0;
        start_pc   = 16'(2 * region_words);
        @(negedge clk);
        service_cycle();
        start = 1'b0;
        report_test("relaunch", errors_before);

        // Running warps keep getting launch pulses that must be dropped
        errors_before = errors;
        cycles        = 0;
        while ((dispatched < total || warps_active != '0) && cycles < timeout_cycles) begin
            @(negedge clk);
            service_cycle();
            relaunch_running();
            cycles++;
        end
        if (dispatched < total || warps_active != '0) begin
            report_problem($sformatf("timed out after %0d cycles waiting for warps to retire",
                                     timeout_cycles));
            aborted = 1'b1;
        end
        report_test("stream", errors_before);

        if (!aborted) begin
            errors_before = errors;
            repeat (8) begin
                @(negedge clk);
                service_cycle();
            end
            if (dispatched != total) begin
                report_mismatch("drain count", 32'(total), 32'(dispatched));
            end
            for (int w = 0; w < `BGPU_NUM_WARPS; w++) begin
                if (exp_head[w] != exp_cnt[w]) begin
                    report_mismatch($sformatf("drain warp %0d entries", w),
                                    32'(exp_cnt[w]), 32'(exp_head[w]));
                end
            end
            if (warps_active != '0) begin
                report_mismatch("drain active", 32'h0, 32'(warps_active));
            end
            if (disp_valid) begin
                report_problem("dispatch output still valid after all warps retired");
            end
            report_test("drain", errors_before);
        end

        $display("tests run %0d, tests failed %0d, errors %0d, entries %0d",
                 tests_run, tests_failed, errors, dispatched);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule : tb_bgpu_frontend

//--- all.f
+incdir+include
logic/bgpu_pkg.sv
logic/warp_fetcher.sv
logic/inst_fetch_wb.sv
logic/decoder.sv
logic/dispatch_buffer.sv
logic/bgpu_frontend.sv
test/bgpu_frontend_asserts.sv
test/tb_bgpu_frontend.sv

//--- run.sh
#!/bin/sh
# Builds the front end testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f all.f \
        --top-module tb_bgpu_frontend -o sim_bgpu_frontend; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_bgpu_frontend)
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "All checks passed"; then
    exit 0
fi
exit 1
